//--- logic/bmc_macros.svh
`ifndef BMC_MACROS_SVH
`define BMC_MACROS_SVH

// Wishbone geometry
`define BMC_ADDR_W 16
`define BMC_DATA_W 16

// ADC results and level checker channels
`define BMC_ADC_W       12
`define BMC_LC_CHANNELS 8
`define BMC_CH_W        3

// Address map, bounds inclusive
`define BMC_SYSCONF_BASE 16'h0000
`define BMC_SYSCONF_HIGH 16'h0003
`define BMC_LEVCHK_BASE  16'h0100
`define BMC_LEVCHK_HIGH  16'h011F
`define BMC_IRQC_BASE    16'h0200
`define BMC_IRQC_HIGH    16'h0203

// Board identity
`define BMC_BOARD_ID           16'h0B4C
`define BMC_REV_MAJOR          8'd1
`define BMC_REV_MINOR          8'd3
`define BMC_DEFAULT_SYS_CONFIG 8'h01

// Level violation and bus error
`define BMC_IRQ_SOURCES 2

`endif

//--- logic/bmc_pkg.sv
`include "bmc_macros.svh"

package bmc_pkg;

  // Master request, shared by all slaves except for stb
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`BMC_ADDR_W-1:0] adr;
    logic [`BMC_DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic [`BMC_DATA_W-1:0] dat;
    logic                   ack;
    logic                   err;
  } wb_rsp_t;

  // One ADC conversion, pushed without handshake
  typedef struct packed {
    logic                  strb;
    logic [`BMC_CH_W-1:0]  channel;
    logic [`BMC_ADC_W-1:0] result;
  } adc_sample_t;

  typedef enum logic [1:0] {
    SEL_SYSCONF = 2'd0,
    SEL_LEVCHK  = 2'd1,
    SEL_IRQC    = 2'd2,
    SEL_NONE    = 2'd3  // No slave at this address
  } slave_sel_e;

  // Bit positions in the interrupt status register
  typedef enum logic [0:0] {
    IRQ_LEVEL_VIOL = 1'b0,
    IRQ_BUS_ERR    = 1'b1
  } irq_src_e;

endpackage

//--- logic/wb_decoder.sv
`timescale 1ns/1ns
`include "bmc_macros.svh"

module wb_decoder (
  input  logic             gclk40,
  input  logic             rst_i,
  input  bmc_pkg::wb_req_t wb_req_i,
  output bmc_pkg::wb_rsp_t wb_rsp_o,
  output bmc_pkg::wb_req_t sysconf_req_o,
  output bmc_pkg::wb_req_t levchk_req_o,
  output bmc_pkg::wb_req_t irqc_req_o,
  input  bmc_pkg::wb_rsp_t sysconf_rsp_i,
  input  bmc_pkg::wb_rsp_t levchk_rsp_i,
  input  bmc_pkg::wb_rsp_t irqc_rsp_i,
  output logic             bus_err_o
);
  import bmc_pkg::*;

  slave_sel_e sel;    // From the live address
  slave_sel_e sel_q;  // Target of the access now answering
  logic       strobe;
  logic       err_q;

  function automatic logic in_region(input logic [`BMC_ADDR_W-1:0] adr,
                                     input logic [`BMC_ADDR_W-1:0] base,
                                     input logic [`BMC_ADDR_W-1:0] high);
    return (adr >= base) && (adr <= high);
  endfunction

  assign strobe = wb_req_i.cyc & wb_req_i.stb;

  always_comb begin
    if (in_region(wb_req_i.adr, `BMC_SYSCONF_BASE, `BMC_SYSCONF_HIGH)) begin
      sel = SEL_SYSCONF;
    end else if (in_region(wb_req_i.adr, `BMC_LEVCHK_BASE, `BMC_LEVCHK_HIGH)) begin
      sel = SEL_LEVCHK;
    end else if (in_region(wb_req_i.adr, `BMC_IRQC_BASE, `BMC_IRQC_HIGH)) begin
      sel = SEL_IRQC;
    end else begin
      sel = SEL_NONE;
    end
  end

  always_comb begin
    sysconf_req_o     = wb_req_i;
    levchk_req_o      = wb_req_i;
    irqc_req_o        = wb_req_i;
    sysconf_req_o.stb = wb_req_i.stb & (sel == SEL_SYSCONF);
    levchk_req_o.stb  = wb_req_i.stb & (sel == SEL_LEVCHK);
    irqc_req_o.stb    = wb_req_i.stb & (sel == SEL_IRQC);
  end

  always_ff @(posedge gclk40) begin
    if (rst_i) begin
      sel_q <= SEL_NONE;
      err_q <= 1'b0;
    end else begin
      if (strobe) begin
        sel_q <= sel;
      end
      // A stb held over the err cycle is the master letting go, not a new access
      err_q <= strobe & (sel == SEL_NONE) & ~err_q;
    end
  end

  always_comb begin
    case (sel_q)
      SEL_SYSCONF: wb_rsp_o = sysconf_rsp_i;
      SEL_LEVCHK:  wb_rsp_o = levchk_rsp_i;
      SEL_IRQC:    wb_rsp_o = irqc_rsp_i;
      default:     wb_rsp_o = '0;
    endcase
    wb_rsp_o.err = wb_rsp_o.err | err_q;
  end

  assign bus_err_o = err_q;  // Same pulse as err

  a_ack_err_excl: assert property (@(posedge gclk40) disable iff (rst_i)
    !(wb_rsp_o.ack && wb_rsp_o.err));

  a_rsp_needs_stb: assert property (@(posedge gclk40) disable iff (rst_i)
    (wb_rsp_o.ack || wb_rsp_o.err) |-> $past(strobe));

endmodule

//--- logic/sys_config.sv
`timescale 1ns/1ns
`include "bmc_macros.svh"

module sys_config (
  input  logic             gclk40,
  input  logic             rst_i,
  input  bmc_pkg::wb_req_t wb_req_i,
  output bmc_pkg::wb_rsp_t wb_rsp_o,
  output logic [7:0]       sys_config_o
);
  localparam logic [`BMC_ADDR_W-1:0] OFFS_ID     = 16'd0;
  localparam logic [`BMC_ADDR_W-1:0] OFFS_REV    = 16'd1;
  localparam logic [`BMC_ADDR_W-1:0] OFFS_CONFIG = 16'd2;

  logic                   strobe;
  logic                   ack_q;
  logic [7:0]             config_q;
  logic [`BMC_ADDR_W-1:0] offs;
  logic [`BMC_DATA_W-1:0] rdata;
  logic [`BMC_DATA_W-1:0] rdata_q;

  // Ignore a stb still high during our own ack
  assign strobe = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign offs   = wb_req_i.adr - `BMC_SYSCONF_BASE;

  always_comb begin
    case (offs)
      OFFS_ID:     rdata = `BMC_BOARD_ID;
      OFFS_REV:    rdata = {`BMC_REV_MAJOR, `BMC_REV_MINOR};
      OFFS_CONFIG: rdata = {8'h00, config_q};
      default:     rdata = '0;
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      config_q <= `BMC_DEFAULT_SYS_CONFIG;
    end else begin
      ack_q <= strobe;
      if (strobe && wb_req_i.we && (offs == OFFS_CONFIG)) begin
        config_q <= wb_req_i.dat[7:0];  // ID and revision stay fixed
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (strobe) begin
      rdata_q <= rdata;
    end
  end

  always_comb begin
    wb_rsp_o     = '0;
    wb_rsp_o.dat = rdata_q;
    wb_rsp_o.ack = ack_q;
  end

  assign sys_config_o = config_q;  // Board configuration pins

  a_ack_single: assert property (@(posedge gclk40) disable iff (rst_i)
    ack_q |=> !ack_q);

endmodule

//--- logic/level_checker.sv
`timescale 1ns/1ns
`include "bmc_macros.svh"

module level_checker (
  input  logic                        gclk40,
  input  logic                        rst_i,
  input  bmc_pkg::wb_req_t            wb_req_i,
  output bmc_pkg::wb_rsp_t            wb_rsp_o,
  input  bmc_pkg::adc_sample_t        adc_i,
  output logic [`BMC_LC_CHANNELS-1:0] v_in_range_o,
  output logic                        level_viol_o
);
  // Low thresholds first, then high thresholds, then the in-range vector
  localparam logic [`BMC_ADDR_W-1:0] OFFS_HIGH = `BMC_LC_CHANNELS;
  localparam logic [`BMC_ADDR_W-1:0] OFFS_VEC  = 2 * `BMC_LC_CHANNELS;

  logic [`BMC_ADC_W-1:0]       thr_low  [`BMC_LC_CHANNELS];
  logic [`BMC_ADC_W-1:0]       thr_high [`BMC_LC_CHANNELS];
  logic [`BMC_LC_CHANNELS-1:0] in_range_q;
  logic                        viol_q;
  logic                        strobe;
  logic                        ack_q;
  logic [`BMC_ADDR_W-1:0]      offs;
  logic [`BMC_CH_W-1:0]        idx;
  logic                        wr_low;
  logic                        wr_high;
  logic [`BMC_DATA_W-1:0]      rdata;
  logic [`BMC_DATA_W-1:0]      rdata_q;
  logic                        sample_ok;

  assign strobe = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign offs   = wb_req_i.adr - `BMC_LEVCHK_BASE;
  assign idx    = offs[`BMC_CH_W-1:0];  // Channel within either threshold bank

  assign wr_low  = strobe & wb_req_i.we & (offs < OFFS_HIGH);
  assign wr_high = strobe & wb_req_i.we & (offs >= OFFS_HIGH) & (offs < OFFS_VEC);

  // Inclusive window on both ends
  assign sample_ok = (adc_i.result >= thr_low[adc_i.channel]) &&
                     (adc_i.result <= thr_high[adc_i.channel]);

  always_ff @(posedge gclk40) begin
    if (rst_i) begin
      for (int i = 0; i < `BMC_LC_CHANNELS; i++) begin
        thr_low[i]  <= '0;
        thr_high[i] <= '1;  // Full scale so nothing is flagged
      end
      in_range_q <= '1;
      viol_q     <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      ack_q  <= strobe;
      viol_q <= adc_i.strb & ~sample_ok;
      if (adc_i.strb) begin
        in_range_q[adc_i.channel] <= sample_ok;
      end
      if (wr_low) begin
        thr_low[idx] <= wb_req_i.dat[`BMC_ADC_W-1:0];
      end
      if (wr_high) begin
        thr_high[idx] <= wb_req_i.dat[`BMC_ADC_W-1:0];
      end
    end
  end

  always_comb begin
    rdata = '0;
    if (offs < OFFS_HIGH) begin
      rdata[`BMC_ADC_W-1:0] = thr_low[idx];
    end else if (offs < OFFS_VEC) begin
      rdata[`BMC_ADC_W-1:0] = thr_high[idx];
    end else if (offs == OFFS_VEC) begin
      rdata[`BMC_LC_CHANNELS-1:0] = in_range_q;
    end
  end

  always_ff @(posedge gclk40) begin
    if (strobe) begin
      rdata_q <= rdata;
    end
  end

  always_comb begin
    wb_rsp_o     = '0;
    wb_rsp_o.dat = rdata_q;
    wb_rsp_o.ack = ack_q;
  end

  assign v_in_range_o = in_range_q;
  assign level_viol_o = viol_q;

  // A violation follows a sample and leaves that channel out of range
  a_viol_after_sample: assert property (@(posedge gclk40) disable iff (rst_i)
    level_viol_o |-> $past(adc_i.strb) && !v_in_range_o[$past(adc_i.channel)]);

endmodule

//--- logic/irq_controller.sv
`timescale 1ns/1ns
`include "bmc_macros.svh"

module irq_controller (
  input  logic                        gclk40,
  input  logic                        rst_i,
  input  bmc_pkg::wb_req_t            wb_req_i,
  output bmc_pkg::wb_rsp_t            wb_rsp_o,
  input  logic [`BMC_IRQ_SOURCES-1:0] irq_src_i,
  output logic                        irq_o
);
  localparam logic [`BMC_ADDR_W-1:0] OFFS_STATUS = 16'd0;
  localparam logic [`BMC_ADDR_W-1:0] OFFS_MASK   = 16'd1;

  logic                        strobe;
  logic                        ack_q;
  logic [`BMC_ADDR_W-1:0]      offs;
  logic [`BMC_IRQ_SOURCES-1:0] status_q;
  logic [`BMC_IRQ_SOURCES-1:0] mask_q;
  logic [`BMC_IRQ_SOURCES-1:0] clr;
  logic                        irq_q;
  logic [`BMC_DATA_W-1:0]      rdata;
  logic [`BMC_DATA_W-1:0]      rdata_q;

  assign strobe = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign offs   = wb_req_i.adr - `BMC_IRQC_BASE;

  // Write 1 to clear
  assign clr = (strobe && wb_req_i.we && (offs == OFFS_STATUS)) ?
               wb_req_i.dat[`BMC_IRQ_SOURCES-1:0] : '0;

  always_ff @(posedge gclk40) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      status_q <= '0;
      mask_q   <= '1;
      irq_q    <= 1'b0;
    end else begin
      ack_q    <= strobe;
      status_q <= (status_q & ~clr) | irq_src_i;  // New pulse beats the clear
      irq_q    <= |(status_q & mask_q);
      if (strobe && wb_req_i.we && (offs == OFFS_MASK)) begin
        mask_q <= wb_req_i.dat[`BMC_IRQ_SOURCES-1:0];
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (offs)
      OFFS_STATUS: rdata[`BMC_IRQ_SOURCES-1:0] = status_q;
      OFFS_MASK:   rdata[`BMC_IRQ_SOURCES-1:0] = mask_q;
      default:     rdata = '0;
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (strobe) begin
      rdata_q <= rdata;
    end
  end

  always_comb begin
    wb_rsp_o     = '0;
    wb_rsp_o.dat = rdata_q;
    wb_rsp_o.ack = ack_q;
  end

  assign irq_o = irq_q;

endmodule

//--- logic/bmc_top.sv
`timescale 1ns/1ns
`include "bmc_macros.svh"

module bmc_top (
  input  logic                        gclk40,
  input  logic                        rst_i,
  input  bmc_pkg::wb_req_t            wb_req_i,
  output bmc_pkg::wb_rsp_t            wb_rsp_o,
  input  bmc_pkg::adc_sample_t        adc_i,
  output logic [7:0]                  sys_config_o,
  output logic [`BMC_LC_CHANNELS-1:0] v_in_range_o,
  output logic                        irq_o
);
  import bmc_pkg::*;

  wb_req_t                     sysconf_req;
  wb_req_t                     levchk_req;
  wb_req_t                     irqc_req;
  wb_rsp_t                     sysconf_rsp;
  wb_rsp_t                     levchk_rsp;
  wb_rsp_t                     irqc_rsp;
  logic                        level_viol;
  logic                        bus_err;
  logic [`BMC_IRQ_SOURCES-1:0] irq_src;

  // Status bit order
  assign irq_src[IRQ_LEVEL_VIOL] = level_viol;
  assign irq_src[IRQ_BUS_ERR]    = bus_err;

  wb_decoder wb_decoder_inst (
    .gclk40(gclk40), .rst_i(rst_i),
    .wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o),
    .sysconf_req_o(sysconf_req), .levchk_req_o(levchk_req), .irqc_req_o(irqc_req),
    .sysconf_rsp_i(sysconf_rsp), .levchk_rsp_i(levchk_rsp), .irqc_rsp_i(irqc_rsp),
    .bus_err_o(bus_err)
  );

  sys_config sys_config_inst (
    .gclk40(gclk40), .rst_i(rst_i),
    .wb_req_i(sysconf_req), .wb_rsp_o(sysconf_rsp),
    .sys_config_o(sys_config_o)
  );

  level_checker level_checker_inst (
    .gclk40(gclk40), .rst_i(rst_i),
    .wb_req_i(levchk_req), .wb_rsp_o(levchk_rsp),
    .adc_i(adc_i),
    .v_in_range_o(v_in_range_o), .level_viol_o(level_viol)
  );

  irq_controller irq_controller_inst (
    .gclk40(gclk40), .rst_i(rst_i),
    .wb_req_i(irqc_req), .wb_rsp_o(irqc_rsp),
    .irq_src_i(irq_src), .irq_o(irq_o)
  );

endmodule

//--- test/tb_bmc.sv
`timescale 1ns/1ns
`include "bmc_macros.svh"

module tb_bmc;
  import bmc_pkg::*;

  localparam int BUS_TIMEOUT = 16;
  localparam int IRQ_TIMEOUT = 8;

  logic                        gclk40;
  logic                        rst_i;
  wb_req_t                     wb_req;
  wb_rsp_t                     wb_rsp;
  adc_sample_t                 adc;
  logic [7:0]                  sys_config;
  logic [`BMC_LC_CHANNELS-1:0] v_in_range;
  logic                        irq;

  logic [15:0]                 lfsr_state = 16'd5641;
  logic [`BMC_ADC_W-1:0]       model_low  [`BMC_LC_CHANNELS];
  logic [`BMC_ADC_W-1:0]       model_high [`BMC_LC_CHANNELS];
  logic [`BMC_IRQ_SOURCES-1:0] model_status;
  logic [`BMC_IRQ_SOURCES-1:0] model_mask;
  logic [`BMC_LC_CHANNELS-1:0] exp_vec;
  logic                        exp_valid = 1'b0;
  int                          stim_errors = 0;
  int                          cmp_errors = 0;  // Counted by the compare process
  int                          tests_failed = 0;

  bmc_top uut (
    .gclk40(gclk40), .rst_i(rst_i),
    .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
    .adc_i(adc),
    .sys_config_o(sys_config), .v_in_range_o(v_in_range), .irq_o(irq)
  );

  initial begin
    gclk40 = 1'b0;
    forever #10 gclk40 = ~gclk40;
  end

  // Fibonacci LFSR on x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      val        = {val[14:0], fb};
    end
    return val;
  endfunction

  // In range when low <= value <= high
  function automatic logic [`BMC_LC_CHANNELS-1:0] expected_in_range(
      input logic [`BMC_LC_CHANNELS-1:0] prev, input logic [`BMC_CH_W-1:0] ch,
      input logic [`BMC_ADC_W-1:0] value);
    logic [`BMC_LC_CHANNELS-1:0] vec;
    vec     = prev;
    vec[ch] = (value >= model_low[ch]) && (value <= model_high[ch]);
    return vec;
  endfunction

  function automatic logic expected_irq();
    return |(model_status & model_mask);
  endfunction

  function automatic int total_errors();
    return stim_errors + cmp_errors;
  endfunction

  // Checks the vector left by the previous edge, then steps the model
  always @(posedge gclk40) begin
    if (exp_valid && (v_in_range !== exp_vec)) begin
      $display("ERROR %0t: v_in_range_o is %b, expected %b", $time, v_in_range, exp_vec);
      cmp_errors++;
    end
    if (rst_i) begin
      exp_vec   = '1;
      exp_valid = 1'b1;
    end else if (adc.strb) begin
      exp_vec = expected_in_range(exp_vec, adc.channel, adc.result);
    end
  end

  // Called and returns on a falling edge
  task automatic bus_access(input logic we, input logic [15:0] adr, input logic [15:0] wdat,
                            output logic [15:0] rdat, output logic acked, output logic erred);
    int cycles;
    cycles     = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    @(negedge gclk40);
    while (!wb_rsp.ack && !wb_rsp.err && (cycles < BUS_TIMEOUT)) begin
      cycles++;
      @(negedge gclk40);
    end
    acked  = wb_rsp.ack;
    erred  = wb_rsp.err;
    rdat   = wb_rsp.dat;
    wb_req = '0;
    if (!acked && !erred) begin
      $display("Bus access at %h got neither ack nor err in %0d cycles", adr, BUS_TIMEOUT);
      stim_errors++;
    end
    @(negedge gclk40);  // Idle cycle
  endtask

  task automatic write_reg(input logic [15:0] adr, input logic [15:0] wdat);
    logic [15:0] rdat;
    logic        acked;
    logic        erred;
    bus_access(1'b1, adr, wdat, rdat, acked, erred);
    if (!acked) begin
      $display("Write to %h was not acknowledged", adr);
      stim_errors++;
    end
  endtask

  task automatic read_and_compare(input logic [15:0] adr, input logic [15:0] exp,
                                  input string what);
    logic [15:0] rdat;
    logic        acked;
    logic        erred;
    bus_access(1'b0, adr, 16'h0000, rdat, acked, erred);
    if (!acked) begin
      $display("Read of %s at %h was not acknowledged", what, adr);
      stim_errors++;
    end else if (rdat !== exp) begin
      $display("ERROR %0t: %s reads %h, expected %h", $time, what, rdat, exp);
      stim_errors++;
    end
  endtask

  task automatic clear_status(input logic [`BMC_IRQ_SOURCES-1:0] bits);
    write_reg(`BMC_IRQC_BASE, 16'(bits));
    model_status = model_status & ~bits;  // Write 1 to clear
  endtask

  task automatic send_sample(input logic [`BMC_CH_W-1:0] ch, input logic [`BMC_ADC_W-1:0] value);
    if ((value < model_low[ch]) || (value > model_high[ch])) begin
      model_status[IRQ_LEVEL_VIOL] = 1'b1;
    end
    adc.strb    = 1'b1;
    adc.channel = ch;
    adc.result  = value;
    @(negedge gclk40);
    adc.strb = 1'b0;
  endtask

  task automatic wait_irq(input logic level, input string what);
    int cycles;
    cycles = 0;
    while ((irq !== level) && (cycles < IRQ_TIMEOUT)) begin
      cycles++;
      @(negedge gclk40);
    end
    if (irq !== level) begin
      $display("irq_o did not go to %b within %0d cycles %s", level, IRQ_TIMEOUT, what);
      stim_errors++;
    end
  endtask

  task automatic hold_irq(input int cycles, input string what);
    for (int i = 0; i < cycles; i++) begin
      @(negedge gclk40);
      if (irq !== expected_irq()) begin
        $display("ERROR %0t: irq_o is %b %s, expected %b", $time, irq, what, expected_irq());
        stim_errors++;
      end
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    int errs;
    errs = total_errors() - errs_before;
    if (errs == 0) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", num, name, errs);
      tests_failed++;
    end
  endtask

  initial begin
    logic [15:0] rdat;
    logic        acked;
    logic        erred;
    int          errs;
    rst_i  = 1'b1;
    wb_req = '0;
    adc    = '0;
    for (int i = 0; i < `BMC_LC_CHANNELS; i++) begin
      model_low[i]  = '0;
      model_high[i] = '1;
    end
    model_status = '0;
    model_mask   = '1;
    repeat (3) @(negedge gclk40);
    rst_i = 1'b0;

    errs = total_errors();
    if ((sys_config !== `BMC_DEFAULT_SYS_CONFIG) || (v_in_range !== '1) || (irq !== 1'b0)) begin
      $display("ERROR %0t: after reset config %h, in-range %b, irq %b", $time,
               sys_config, v_in_range, irq);
      stim_errors++;
    end
    read_and_compare(`BMC_SYSCONF_BASE, `BMC_BOARD_ID, "board ID");
    read_and_compare(`BMC_SYSCONF_BASE + 16'd1,
                     (16'(`BMC_REV_MAJOR) << 8) | 16'(`BMC_REV_MINOR), "revision");
    write_reg(`BMC_SYSCONF_BASE + 16'd2, 16'h00A5);
    if (sys_config !== 8'hA5) begin
      $display("ERROR %0t: sys_config_o is %h, expected a5", $time, sys_config);
      stim_errors++;
    end
    read_and_compare(`BMC_SYSCONF_BASE + 16'd2, 16'h00A5, "configuration byte");
    write_reg(`BMC_SYSCONF_BASE, 16'h1234);  // Read-only
    read_and_compare(`BMC_SYSCONF_BASE, `BMC_BOARD_ID, "board ID after write");
    report_test(1, "reset and identity", errs);

    errs = total_errors();
    for (int i = 0; i < `BMC_LC_CHANNELS; i++) begin
      model_low[i]  = 12'(random_bits(11));
      model_high[i] = model_low[i] + 12'(random_bits(11));
      write_reg(`BMC_LEVCHK_BASE + 16'(i), 16'(model_low[i]));
      write_reg(`BMC_LEVCHK_BASE + 16'(i + `BMC_LC_CHANNELS), 16'(model_high[i]));
    end
    for (int i = 0; i < `BMC_LC_CHANNELS; i++) begin
      read_and_compare(`BMC_LEVCHK_BASE + 16'(i), 16'(model_low[i]), "low threshold");
      read_and_compare(`BMC_LEVCHK_BASE + 16'(i + `BMC_LC_CHANNELS), 16'(model_high[i]),
                       "high threshold");
    end
    read_and_compare(`BMC_LEVCHK_BASE + 16'd16, 16'(exp_vec), "in-range vector");
    read_and_compare(`BMC_LEVCHK_BASE + 16'd17, 16'h0000, "unused offset");
    report_test(2, "threshold registers", errs);

    errs = total_errors();
    for (int n = 0; n < 200; n++) begin
      send_sample(3'(random_bits(3)), 12'(random_bits(12)));
      if (random_bits(1) == 16'd1) begin
        @(negedge gclk40);  // Random gap between samples
      end
    end
    repeat (2) @(negedge gclk40);  // Last sample reaches the compare process
    report_test(3, "sample comparison", errs);

    errs = total_errors();
    read_and_compare(`BMC_IRQC_BASE, 16'(model_status), "status after samples");
    wait_irq(expected_irq(), "after samples");
    model_low[0]  = 12'h100;
    model_high[0] = 12'h200;
    write_reg(`BMC_LEVCHK_BASE, 16'h0100);
    write_reg(`BMC_LEVCHK_BASE + 16'd8, 16'h0200);
    clear_status('1);
    wait_irq(expected_irq(), "after clearing all status");
    send_sample(3'd0, 12'h100);  // Both bounds count as in range
    send_sample(3'd0, 12'h200);
    hold_irq(4, "after in-range samples");
    read_and_compare(`BMC_IRQC_BASE, 16'(model_status), "status after in-range samples");
    send_sample(3'd0, 12'h0FF);  // Just below low
    wait_irq(expected_irq(), "after violation");
    read_and_compare(`BMC_IRQC_BASE, 16'(model_status), "status after violation");
    clear_status(2'b01);
    wait_irq(expected_irq(), "after clearing bit 0");
    model_mask = 2'b10;
    write_reg(`BMC_IRQC_BASE + 16'd1, 16'(model_mask));
    read_and_compare(`BMC_IRQC_BASE + 16'd1, 16'(model_mask), "mask");
    send_sample(3'd0, 12'h201);  // Just above high while masked
    hold_irq(4, "after masked violation");
    read_and_compare(`BMC_IRQC_BASE, 16'(model_status), "status while masked");
    clear_status(2'b01);
    model_mask = '1;
    write_reg(`BMC_IRQC_BASE + 16'd1, 16'(model_mask));
    report_test(4, "level-violation interrupt", errs);

    errs = total_errors();
    bus_access(1'b0, 16'h0400, 16'h0000, rdat, acked, erred);
    if (acked || !erred) begin
      $display("ERROR %0t: access at 0400 gave ack %b err %b, expected err only", $time,
               acked, erred);
      stim_errors++;
    end
    model_status[IRQ_BUS_ERR] = 1'b1;
    wait_irq(expected_irq(), "after bus error");
    read_and_compare(`BMC_IRQC_BASE, 16'(model_status), "status after bus error");
    read_and_compare(`BMC_SYSCONF_BASE + 16'd2, 16'h00A5, "configuration after bus error");
    clear_status('1);
    wait_irq(expected_irq(), "after final clear");
    report_test(5, "unmapped address", errs);

    $display("Tests run 5, tests failed %0d, errors %0d", tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+logic
logic/bmc_pkg.sv
logic/wb_decoder.sv
logic/sys_config.sv
logic/level_checker.sv
logic/irq_controller.sv
logic/bmc_top.sv
test/tb_bmc.sv

//--- Makefile
SRCS := verilog.f $(wildcard logic/*.sv logic/*.svh test/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_bmc: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_bmc

# Fails unless the pass line shows up in the simulator output
run: obj_dir/Vtb_bmc
	./obj_dir/Vtb_bmc | awk '{ print } /^Result: PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
